//--- design/sifh_pkg.sv
package sifh_pkg;

    // Controller phases
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        BUILD = 3'd1,   // Accumulating samples
        FIND  = 3'd2,   // Peak search pass
        SHOW  = 3'd3,   // Result held for consumer
        CLEAR = 3'd4    // Wiping counters
    } ctrl_state_t;

    // Default sizing
    localparam int DEF_PIXELS  = 4;
    localparam int DEF_BINS    = 16;    // Power of two
    localparam int DEF_ACQS    = 8;
    localparam int DEF_DATA_W  = 8;
    localparam int DEF_COUNT_W = 8;

endpackage

//--- design/hist_if.sv
interface hist_if #(
    parameter int PIXELS  = sifh_pkg::DEF_PIXELS,
    parameter int BINS    = sifh_pkg::DEF_BINS,
    parameter int COUNT_W = sifh_pkg::DEF_COUNT_W
);
    localparam int BIN_W = $clog2(BINS);
    localparam int PIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;

    // Update side
    logic               upd_valid;
    logic [PIX_W-1:0]   upd_pixel;
    logic [BIN_W-1:0]   upd_bin;

    // Scan side
    logic               rd_en;
    logic [PIX_W-1:0]   rd_pixel;
    logic [BIN_W-1:0]   rd_bin;
    logic [COUNT_W-1:0] rd_count;   // One cycle after rd_en

    modport update (output upd_valid, upd_pixel, upd_bin);
    modport scan (output rd_en, rd_pixel, rd_bin, input rd_count);
    modport mem (
        input  upd_valid, upd_pixel, upd_bin, rd_en, rd_pixel, rd_bin,
        output rd_count
    );
endinterface

//--- design/sample_decoder.sv
module sample_decoder #(
    parameter int PIXELS = sifh_pkg::DEF_PIXELS,
    parameter int BINS   = sifh_pkg::DEF_BINS,
    parameter int ACQS   = sifh_pkg::DEF_ACQS,
    parameter int DATA_W = sifh_pkg::DEF_DATA_W
) (
    input  logic              clk,
    input  logic              res,
    input  logic              in_valid,
    input  logic [DATA_W-1:0] in_data,
    input  logic              accept_en,
    output logic              in_ready,
    hist_if.update            upd,
    output logic              done_build
);
    localparam int BIN_W = $clog2(BINS);
    localparam int PIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam int ACQ_W = (ACQS > 1) ? $clog2(ACQS) : 1;

    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             fire;
    logic             last_pix;
    logic             last_acq;

    assign in_ready = accept_en;
    assign fire     = in_valid && in_ready;
    assign last_pix = (pix_cnt == PIX_W'(PIXELS - 1));
    assign last_acq = (acq_cnt == ACQ_W'(ACQS - 1));

    assign upd.upd_valid = fire;
    assign upd.upd_pixel = pix_cnt;
    assign upd.upd_bin   = in_data[DATA_W-1 -: BIN_W];   // Time bin from upper bits

    // Last sample of the last acquisition
    assign done_build = fire && last_pix && last_acq;

    // Round-robin pixel index, acquisition index behind it
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (fire) begin
            if (last_pix) begin
                pix_cnt <= '0;
                acq_cnt <= last_acq ? '0 : acq_cnt + 1'b1;
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    // Controller must close the input right after the build completes
    ap_closed_after_build: assert property (
        @(posedge clk) disable iff (!res)
        done_build |=> !accept_en && !upd.upd_valid
    );

endmodule

//--- design/histogram_ctrl.sv
module histogram_ctrl #(
    parameter int PIXELS = sifh_pkg::DEF_PIXELS,
    parameter int BINS   = sifh_pkg::DEF_BINS
) (
    input  logic clk,
    input  logic res,
    input  logic first_sample,
    input  logic done_build,
    input  logic scan_done,
    input  logic result_taken,
    output logic accept_en,
    output logic scan_start,
    output logic show_en,
    output logic clr_en,
    output logic [((PIXELS > 1) ? $clog2(PIXELS) : 1) + $clog2(BINS) - 1:0] clr_addr,
    output logic busy
);
    localparam int BIN_W  = $clog2(BINS);
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam int ADDR_W = PIX_W + BIN_W;
    localparam logic [ADDR_W-1:0] CLR_LAST = ADDR_W'(PIXELS * BINS - 1);

    sifh_pkg::ctrl_state_t state;
    logic [1:0]            drain_cnt;   // Pipeline drain after last sample

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= sifh_pkg::IDLE;
            drain_cnt  <= 2'd0;
            clr_addr   <= '0;
            scan_start <= 1'b0;
        end else begin
            scan_start <= 1'b0;
            case (state)
                sifh_pkg::IDLE: begin
                    if (first_sample) begin
                        state <= sifh_pkg::BUILD;
                        if (done_build) begin
                            drain_cnt <= 2'd2;   // Single-sample run
                        end
                    end
                end
                sifh_pkg::BUILD: begin
                    if (done_build) begin
                        drain_cnt <= 2'd2;
                    end else if (drain_cnt != 2'd0) begin
                        drain_cnt <= drain_cnt - 2'd1;
                        if (drain_cnt == 2'd1) begin
                            state      <= sifh_pkg::FIND;
                            scan_start <= 1'b1;
                        end
                    end
                end
                sifh_pkg::FIND: begin
                    if (scan_done) begin
                        state <= sifh_pkg::SHOW;
                    end
                end
                sifh_pkg::SHOW: begin
                    if (result_taken) begin
                        state    <= sifh_pkg::CLEAR;
                        clr_addr <= '0;
                    end
                end
                sifh_pkg::CLEAR: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == CLR_LAST) begin
                        state <= sifh_pkg::IDLE;
                    end
                end
                default: state <= sifh_pkg::IDLE;
            endcase
        end
    end

    assign accept_en = (state == sifh_pkg::IDLE) ||
                       (state == sifh_pkg::BUILD && drain_cnt == 2'd0);
    assign show_en   = (state == sifh_pkg::SHOW);
    assign clr_en    = (state == sifh_pkg::CLEAR);
    assign busy      = (state != sifh_pkg::IDLE);

    // Peak search finishes only inside FIND
    ap_scan_done_in_find: assert property (
        @(posedge clk) disable iff (!res)
        scan_done |-> state == sifh_pkg::FIND
    );

endmodule

//--- design/histogram_ram.sv
module histogram_ram #(
    parameter int PIXELS  = sifh_pkg::DEF_PIXELS,
    parameter int BINS    = sifh_pkg::DEF_BINS,
    parameter int COUNT_W = sifh_pkg::DEF_COUNT_W
) (
    input  logic  clk,
    input  logic  res,
    hist_if.mem   mem,
    input  logic  clr_en,
    input  logic [((PIXELS > 1) ? $clog2(PIXELS) : 1) + $clog2(BINS) - 1:0] clr_addr
);
    localparam int BIN_W  = $clog2(BINS);
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam int ADDR_W = PIX_W + BIN_W;
    localparam int DEPTH  = PIXELS * BINS;

    logic [COUNT_W-1:0] cnt_mem [DEPTH];
    logic [ADDR_W-1:0]  upd_addr;
    logic [ADDR_W-1:0]  rd_addr;
    logic               s1_valid;
    logic [ADDR_W-1:0]  s1_addr;
    logic [COUNT_W-1:0] s1_cnt;
    logic [COUNT_W-1:0] new_cnt;

    // Pixel-major layout, bins contiguous
    assign upd_addr = {mem.upd_pixel, mem.upd_bin};
    assign rd_addr  = {mem.rd_pixel, mem.rd_bin};

    assign new_cnt = (&s1_cnt) ? s1_cnt : s1_cnt + 1'b1;   // Saturating increment

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= mem.upd_valid;
        end
    end

    // Stage one read, plus scan port
    always_ff @(posedge clk) begin
        s1_addr <= upd_addr;
        if (s1_valid && s1_addr == upd_addr) begin
            s1_cnt <= new_cnt;   // Write still in flight
        end else begin
            s1_cnt <= cnt_mem[upd_addr];
        end
        if (mem.rd_en) begin
            mem.rd_count <= cnt_mem[rd_addr];
        end
    end

    // Stage two write
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < DEPTH; i++) begin
                cnt_mem[i] <= '0;
            end
        end else if (clr_en) begin
            cnt_mem[clr_addr] <= '0;
        end else if (s1_valid) begin
            cnt_mem[s1_addr] <= new_cnt;
        end
    end

    // Clear pass only after the update pipeline is empty
    ap_clear_vs_update: assert property (
        @(posedge clk) disable iff (!res)
        clr_en |-> !mem.upd_valid && !s1_valid
    );

endmodule

//--- design/peak_finder.sv
module peak_finder #(
    parameter int PIXELS  = sifh_pkg::DEF_PIXELS,
    parameter int BINS    = sifh_pkg::DEF_BINS,
    parameter int COUNT_W = sifh_pkg::DEF_COUNT_W
) (
    input  logic                                        clk,
    input  logic                                        res,
    input  logic                                        scan_start,
    hist_if.scan                                        scan,
    output logic [((PIXELS > 1) ? $clog2(PIXELS) : 1)-1:0] peak_pixel,
    output logic [$clog2(BINS)-1:0]                     peak_bin,
    output logic                                        peak_valid,
    output logic                                        scan_done
);
    localparam int BIN_W = $clog2(BINS);
    localparam int PIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam logic [BIN_W-1:0] BIN_LAST = BIN_W'(BINS - 1);
    localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(PIXELS - 1);

    logic               running;
    logic [PIX_W-1:0]   pix_q;
    logic [BIN_W-1:0]   bin_q;
    logic               d_valid;     // rd_count holds data this cycle
    logic [PIX_W-1:0]   d_pixel;
    logic [BIN_W-1:0]   d_bin;
    logic [COUNT_W-1:0] max_cnt;
    logic [BIN_W-1:0]   max_bin;
    logic               take;
    logic [BIN_W-1:0]   win_bin;

    assign scan.rd_en    = running;
    assign scan.rd_pixel = pix_q;
    assign scan.rd_bin   = bin_q;

    // Address walk over every pixel and bin
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            running <= 1'b0;
            pix_q   <= '0;
            bin_q   <= '0;
            d_valid <= 1'b0;
        end else begin
            d_valid <= running;
            if (scan_start) begin
                running <= 1'b1;
                pix_q   <= '0;
                bin_q   <= '0;
            end else if (running) begin
                bin_q <= bin_q + 1'b1;   // Wraps at BINS
                if (bin_q == BIN_LAST) begin
                    if (pix_q == PIX_LAST) begin
                        running <= 1'b0;
                        pix_q   <= '0;
                    end else begin
                        pix_q <= pix_q + 1'b1;
                    end
                end
            end
        end
    end

    // First bin restarts the maximum, strictly greater keeps the lower bin on ties
    assign take    = (d_bin == '0) || (scan.rd_count > max_cnt);
    assign win_bin = take ? d_bin : max_bin;

    always_ff @(posedge clk) begin
        d_pixel <= pix_q;
        d_bin   <= bin_q;
        if (d_valid && take) begin
            max_cnt <= scan.rd_count;
            max_bin <= d_bin;
        end
    end

    assign peak_valid = d_valid && (d_bin == BIN_LAST);
    assign peak_pixel = d_pixel;
    assign peak_bin   = win_bin;
    assign scan_done  = peak_valid && (d_pixel == PIX_LAST);

    ap_scan_length: assert property (
        @(posedge clk) disable iff (!res)
        scan_start |-> ##(PIXELS * BINS + 1) scan_done
    );

endmodule

//--- design/peak_collector.sv
module peak_collector #(
    parameter int PIXELS = sifh_pkg::DEF_PIXELS,
    parameter int BINS   = sifh_pkg::DEF_BINS
) (
    input  logic                                           clk,
    input  logic                                           res,
    input  logic                                           peak_valid,
    input  logic [((PIXELS > 1) ? $clog2(PIXELS) : 1)-1:0] peak_pixel,
    input  logic [$clog2(BINS)-1:0]                        peak_bin,
    input  logic                                           show_en,
    input  logic                                           result_ready,
    output logic                                           result_valid,
    output logic [PIXELS*$clog2(BINS)-1:0]                 result,
    output logic                                           result_taken
);
    localparam int BIN_W = $clog2(BINS);

    logic [PIXELS-1:0][BIN_W-1:0] slots;   // Pixel 0 in the low bits

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            slots <= '0;
        end else if (peak_valid) begin
            slots[peak_pixel] <= peak_bin;
        end
    end

    assign result       = slots;
    assign result_valid = show_en;
    assign result_taken = result_valid && result_ready;

    // Held result under back-pressure
    ap_result_hold: assert property (
        @(posedge clk) disable iff (!res)
        result_valid && !result_ready |=> result_valid && $stable(result)
    );

endmodule

//--- design/sifh_top.sv
module sifh_top #(
    parameter int PIXELS  = sifh_pkg::DEF_PIXELS,
    parameter int BINS    = sifh_pkg::DEF_BINS,
    parameter int ACQS    = sifh_pkg::DEF_ACQS,
    parameter int DATA_W  = sifh_pkg::DEF_DATA_W,
    parameter int COUNT_W = sifh_pkg::DEF_COUNT_W
) (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           in_valid,
    input  logic [DATA_W-1:0]              in_data,
    output logic                           in_ready,
    output logic                           result_valid,
    input  logic                           result_ready,
    output logic [PIXELS*$clog2(BINS)-1:0] result,
    output logic                           busy
);
    localparam int BIN_W  = $clog2(BINS);
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam int ADDR_W = PIX_W + BIN_W;

    logic              accept_en;
    logic              done_build;
    logic              scan_start;
    logic              scan_done;
    logic              show_en;
    logic              clr_en;
    logic [ADDR_W-1:0] clr_addr;
    logic              peak_valid;
    logic [PIX_W-1:0]  peak_pixel;
    logic [BIN_W-1:0]  peak_bin;
    logic              result_taken;

    hist_if #(.PIXELS(PIXELS), .BINS(BINS), .COUNT_W(COUNT_W)) hist ();

    sample_decoder #(.PIXELS(PIXELS), .BINS(BINS), .ACQS(ACQS), .DATA_W(DATA_W)) u_dec (
        .clk, .res, .in_valid, .in_data, .accept_en, .in_ready,
        .upd(hist.update), .done_build
    );

    histogram_ctrl #(.PIXELS(PIXELS), .BINS(BINS)) u_ctrl (
        .clk, .res,
        .first_sample(hist.upd_valid),   // Any accepted sample
        .done_build, .scan_done, .result_taken,
        .accept_en, .scan_start, .show_en, .clr_en, .clr_addr, .busy
    );

    histogram_ram #(.PIXELS(PIXELS), .BINS(BINS), .COUNT_W(COUNT_W)) u_ram (
        .clk, .res, .mem(hist.mem), .clr_en, .clr_addr
    );

    peak_finder #(.PIXELS(PIXELS), .BINS(BINS), .COUNT_W(COUNT_W)) u_find (
        .clk, .res, .scan_start, .scan(hist.scan),
        .peak_pixel, .peak_bin, .peak_valid, .scan_done
    );

    peak_collector #(.PIXELS(PIXELS), .BINS(BINS)) u_coll (
        .clk, .res, .peak_valid, .peak_pixel, .peak_bin, .show_en,
        .result_ready, .result_valid, .result, .result_taken
    );

endmodule

//--- verif/sifh_tb.sv
module sifh_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PIXELS  = sifh_pkg::DEF_PIXELS;
    localparam int BINS    = sifh_pkg::DEF_BINS;
    localparam int ACQS    = sifh_pkg::DEF_ACQS;
    localparam int DATA_W  = sifh_pkg::DEF_DATA_W;
    localparam int COUNT_W = 3;                      // Small counters reach saturation
    localparam int BIN_W   = $clog2(BINS);
    localparam int RES_W   = PIXELS * BIN_W;
    localparam int SAT     = (1 << COUNT_W) - 1;
    localparam int NRUNS   = 7;

    localparam logic [1:0] PAT_CONST  = 2'd0;
    localparam logic [1:0] PAT_RANDOM = 2'd1;
    localparam logic [1:0] PAT_TIE    = 2'd2;
    localparam logic [1:0] PAT_SPARSE = 2'd3;

    typedef struct packed {
        logic [1:0] pat;
        logic [3:0] bin;     // Fixed bin or base bin of the pattern
        logic [2:0] gap;     // Idle cycle chance in eighths
        logic [7:0] stall;   // Cycles before result_ready
    } run_t;

    logic              clk;
    logic              res;
    logic              in_valid;
    logic [DATA_W-1:0] in_data;
    logic              in_ready;
    logic              result_valid;
    logic              result_ready;
    logic [RES_W-1:0]  result;
    logic              busy;

    run_t        runs [NRUNS];
    logic [31:0] lfsr = 32'h5c1a;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit;

    sifh_top #(
        .PIXELS(PIXELS), .BINS(BINS), .ACQS(ACQS), .DATA_W(DATA_W), .COUNT_W(COUNT_W)
    ) DUT (
        .clk, .res, .in_valid, .in_data, .in_ready,
        .result_valid, .result_ready, .result, .busy
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not complete within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic send_sample(input logic [DATA_W-1:0] data, input logic gap);
        @(negedge clk);
        if (gap) begin
            in_valid = 1'b0;
            @(negedge clk);
        end
        in_valid = 1'b1;
        in_data  = data;
        while (!in_ready) @(negedge clk);   // Transfer on the next rising edge
    endtask

    task automatic apply_run(input run_t run);
        int               counts [PIXELS][BINS];
        int               p;
        int               a;
        int               best;
        int               best_bin;
        logic [31:0]      bits;
        logic [BIN_W-1:0] bin;
        logic             gap;
        logic [RES_W-1:0] expected;
        for (int i = 0; i < PIXELS; i++) begin
            for (int b = 0; b < BINS; b++) counts[i][b] = 0;
        end
        for (int k = 0; k < PIXELS * ACQS; k++) begin
            p   = k % PIXELS;
            a   = k / PIXELS;
            gap = 1'b0;
            if (run.gap != 0) begin
                take_bits(3, bits);
                gap = (bits < 32'(run.gap));
            end
            case (run.pat)
                PAT_CONST: bin = run.bin;
                PAT_RANDOM: begin
                    take_bits(BIN_W, bits);
                    bin = bits[BIN_W-1:0];
                end
                PAT_TIE: bin = a[0] ? run.bin + BIN_W'(p) : run.bin + BIN_W'(p + 9);
                default: bin = (a < 3) ? run.bin + BIN_W'(p) : run.bin + BIN_W'(p + 4);
            endcase
            if (counts[p][bin] < SAT) counts[p][bin]++;
            send_sample({bin, (DATA_W - BIN_W)'(k)}, gap);
        end
        @(negedge clk);
        in_valid = 1'b0;

        // First maximum per pixel
        expected = '0;
        for (int i = 0; i < PIXELS; i++) begin
            best     = counts[i][0];
            best_bin = 0;
            for (int b = 1; b < BINS; b++) begin
                if (counts[i][b] > best) begin
                    best     = counts[i][b];
                    best_bin = b;
                end
            end
            expected[i*BIN_W +: BIN_W] = BIN_W'(best_bin);
        end

        while (!result_valid) @(negedge clk);
        check_value("result", 32'(result), 32'(expected));
        check_value("in_ready", 32'(in_ready), 32'd0);
        check_value("busy", 32'(busy), 32'd1);
        repeat (run.stall) begin
            @(negedge clk);
            check_value("result_valid", 32'(result_valid), 32'd1);
            check_value("result", 32'(result), 32'(expected));
            check_value("in_ready", 32'(in_ready), 32'd0);
        end
        result_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        check_value("result_valid", 32'(result_valid), 32'd0);
    endtask

    initial begin
        int max_stall;
        clk          = 1'b0;
        res          = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        result_ready = 1'b0;

        // Sparse rows follow full runs so stale counts would show
        runs[0] = '{PAT_CONST,  4'd5,  3'd0, 8'd0};
        runs[1] = '{PAT_SPARSE, 4'd9,  3'd2, 8'd3};
        runs[2] = '{PAT_RANDOM, 4'd0,  3'd3, 8'd6};
        runs[3] = '{PAT_TIE,    4'd2,  3'd0, 8'd2};
        runs[4] = '{PAT_SPARSE, 4'd1,  3'd1, 8'd0};
        runs[5] = '{PAT_CONST,  4'd15, 3'd1, 8'd0};
        runs[6] = '{PAT_RANDOM, 4'd0,  3'd0, 8'd1};

        max_stall = 0;
        for (int i = 0; i < NRUNS; i++) begin
            if (int'(runs[i].stall) > max_stall) max_stall = int'(runs[i].stall);
        end
        cycle_limit = NRUNS * (4 * PIXELS * ACQS + 2 * PIXELS * BINS + max_stall) + 200;

        repeat (5) @(negedge clk);
        res = 1'b1;
        @(negedge clk);
        check_value("result_valid", 32'(result_valid), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_value("in_ready", 32'(in_ready), 32'd1);

        for (int r = 0; r < NRUNS; r++) begin
            apply_run(runs[r]);
        end
        repeat (2) @(negedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
design/sifh_pkg.sv
design/hist_if.sv
design/sample_decoder.sv
design/histogram_ctrl.sv
design/histogram_ram.sv
design/peak_finder.sv
design/peak_collector.sv
design/sifh_top.sv
verif/sifh_tb.sv

//--- Makefile
# Verilator simulation of the histogram peak finder

VERILATOR ?= verilator
TOP       ?= sifh_tb
FILELIST  ?= all.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST LOG BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
